// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fpu_ext
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== fpu_add_sub.sv ====
// truncating single-precision adder/subtractor with ftz, special cases and flags
`timescale 1ns/1ns
`default_nettype none

module fpu_add_sub (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        sub,
  output logic [31:0] sum,
  output logic [4:0]  flags
);

  logic               sa, sb;
  logic [7:0]         ea, eb;
  logic [23:0]        ma, mb;
  logic               a_inf, b_inf, a_nan, b_nan, a_snan, b_snan;
  logic               a_big;
  logic               s_big, s_small;
  logic [7:0]         e_big, e_small, e_diff;
  logic [23:0]        m_big, m_small;
  logic [71:0]        m_shift;
  logic               sticky;
  logic [49:0]        op_big, op_small, mag;
  logic [5:0]         lz;
  logic [49:0]        norm;
  logic signed [9:0]  exp_n;

  // unpack, subnormals flushed to zero
  assign sa = a[31];
  assign sb = b[31] ^ sub; // subtract as add of negated b
  assign ea = a[30:23];
  assign eb = b[30:23];
  assign ma = (ea == 8'h00) ? 24'd0 : {1'b1, a[22:0]};
  assign mb = (eb == 8'h00) ? 24'd0 : {1'b1, b[22:0]};

  assign a_inf  = (ea == 8'hff) && (a[22:0] == 23'd0);
  assign b_inf  = (eb == 8'hff) && (b[22:0] == 23'd0);
  assign a_nan  = (ea == 8'hff) && (a[22:0] != 23'd0);
  assign b_nan  = (eb == 8'hff) && (b[22:0] != 23'd0);
  assign a_snan = a_nan && !a[22];
  assign b_snan = b_nan && !b[22];

  // order by magnitude so the difference never goes negative
  assign a_big = {ea, ma} >= {eb, mb};
  assign {s_big, e_big, m_big}       = a_big ? {sa, ea, ma} : {sb, eb, mb};
  assign {s_small, e_small, m_small} = a_big ? {sb, eb, mb} : {sa, ea, ma};

  // align small operand, low 24 bits only feed the sticky
  assign e_diff  = e_big - e_small;
  assign m_shift = {m_small, 48'd0} >> e_diff;
  assign sticky  = (e_diff >= 8'd72) ? |m_small : |m_shift[23:0];

  // carry | mantissa | guard zone | sticky
  assign op_big   = {1'b0, m_big, 25'd0};
  assign op_small = {1'b0, m_shift[71:24], sticky};
  assign mag      = (s_big == s_small) ? op_big + op_small : op_big - op_small;

  // leading zero count, highest set bit wins
  always_comb begin
    lz = 6'd0;
    for (int i = 0; i < 50; i++) begin
      if (mag[i]) lz = 6'(49 - i);
    end
  end

  assign norm  = mag << lz;                                    // leading one to bit 49
  assign exp_n = $signed({2'b00, e_big}) + 10'sd1 - $signed({4'b0000, lz});

  always_comb begin
    flags = 5'd0;
    if (a_nan || b_nan) begin
      sum                     = fpu_pkg::CANON_NAN;
      flags[fpu_pkg::FLAG_NV] = a_snan || b_snan; // quiet nan passes silently
    end else if (a_inf && b_inf && (sa != sb)) begin
      sum                     = fpu_pkg::CANON_NAN; // inf - inf
      flags[fpu_pkg::FLAG_NV] = 1'b1;
    end else if (a_inf) begin
      sum = {sa, 8'hff, 23'd0};
    end else if (b_inf) begin
      sum = {sb, 8'hff, 23'd0};
    end else if (mag == 50'd0) begin
      sum = {s_big & s_small, 31'd0}; // exact cancel gives +0
    end else if (exp_n >= 10'sd255) begin
      // rtz clamps to largest finite
      sum                     = {s_big, 8'hfe, {23{1'b1}}};
      flags[fpu_pkg::FLAG_OF] = 1'b1;
      flags[fpu_pkg::FLAG_NX] = 1'b1;
    end else if (exp_n <= 10'sd0) begin
      sum                     = {s_big, 31'd0}; // below normal range, ftz
      flags[fpu_pkg::FLAG_UF] = 1'b1;
      flags[fpu_pkg::FLAG_NX] = 1'b1;
    end else begin
      sum                     = {s_big, exp_n[7:0], norm[48:26]}; // truncate
      flags[fpu_pkg::FLAG_NX] = |norm[25:0];
    end
  end

endmodule

`default_nettype wire

// ==== fpu_decode.sv ====
// decode stage of the fpu extension
`timescale 1ns/1ns
`default_nettype none

module fpu_decode (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 start,
  input  fpu_pkg::fpu_instr_u  instr,
  input  logic [31:0]          load_data,
  output logic [4:0]           rs1_addr,
  output logic [4:0]           rs2_addr,
  input  logic [31:0]          rs1_data,
  input  logic [31:0]          rs2_data,
  output fpu_pkg::dec_ex_t     dec_ex
);

  fpu_pkg::fpu_op_e dec_op;
  logic             is_store;

  // classify by opcode, then funct7 for op-fp
  always_comb begin
    dec_op = fpu_pkg::FPU_NONE;
    case (instr.r.opcode)
      fpu_pkg::OP_FLW: dec_op = fpu_pkg::FPU_LOAD;
      fpu_pkg::OP_FSW: dec_op = fpu_pkg::FPU_STORE;
      fpu_pkg::OP_FP: begin
        case (instr.r.funct7)
          fpu_pkg::F7_FADD: dec_op = fpu_pkg::FPU_ADD;
          fpu_pkg::F7_FSUB: dec_op = fpu_pkg::FPU_SUB;
          fpu_pkg::F7_FMUL: dec_op = fpu_pkg::FPU_MUL;
          default:          dec_op = fpu_pkg::FPU_NONE; // unsupported op-fp
        endcase
      end
      default: dec_op = fpu_pkg::FPU_NONE;
    endcase
  end

  assign is_store = (dec_op == fpu_pkg::FPU_STORE);

  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.s.rs2; // fsw data reg, same bits as r-type rs2

  // rf read is combinational, operands captured here
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_ex <= '0;
    end else begin
      dec_ex.valid <= start && (dec_op != fpu_pkg::FPU_NONE);
      dec_ex.op    <= start ? dec_op : fpu_pkg::FPU_NONE;
      if (start) begin
        // store has imm_lo in the rd slot, no destination
        dec_ex.rd        <= is_store ? 5'd0 : instr.r.rd;
        dec_ex.a         <= rs1_data;
        dec_ex.b         <= rs2_data;
        dec_ex.load_data <= load_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fpu_execute.sv ====
// execute stage, operation select and execute-to-result register
`timescale 1ns/1ns
`default_nettype none

module fpu_execute (
  input  logic              CLK,
  input  logic              nRST,
  input  fpu_pkg::dec_ex_t  dec_ex,
  output fpu_pkg::ex_res_t  ex_res
);

  logic [31:0] sum, prod, value;
  logic [4:0]  add_flags, mul_flags, flags;

  fpu_add_sub add_sub_i (
    .a     (dec_ex.a),
    .b     (dec_ex.b),
    .sub   (dec_ex.op == fpu_pkg::FPU_SUB),
    .sum   (sum),
    .flags (add_flags)
  );

  fpu_mul mul_i (
    .a     (dec_ex.a),
    .b     (dec_ex.b),
    .prod  (prod),
    .flags (mul_flags)
  );

  // moves raise no flags
  always_comb begin
    case (dec_ex.op)
      fpu_pkg::FPU_LOAD:  {value, flags} = {dec_ex.load_data, 5'd0};
      fpu_pkg::FPU_STORE: {value, flags} = {dec_ex.b, 5'd0}; // rs2 goes out
      fpu_pkg::FPU_ADD,
      fpu_pkg::FPU_SUB:   {value, flags} = {sum, add_flags};
      fpu_pkg::FPU_MUL:   {value, flags} = {prod, mul_flags};
      default:            {value, flags} = {32'd0, 5'd0};
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_res <= '0;
    end else begin
      ex_res.valid <= dec_ex.valid;
      ex_res.op    <= dec_ex.op;
      ex_res.rd    <= dec_ex.rd;
      ex_res.value <= value;
      ex_res.flags <= flags;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_ext_top.sv ====
// top level of the fpu extension, stages and register file
`timescale 1ns/1ns
`default_nettype none

module fpu_ext_top (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        start,
  input  logic [31:0] instr,
  input  logic [31:0] load_data,
  output logic        done,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        store_valid,
  output logic [31:0] store_data,
  output logic [4:0]  fflags
);

  logic [4:0]       rs1_addr, rs2_addr;
  logic [31:0]      rs1_data, rs2_data;
  fpu_pkg::dec_ex_t dec_ex;
  fpu_pkg::ex_res_t ex_res;

  fpu_decode decode_i (
    .CLK, .nRST, .start,
    .instr     (instr),     // raw word into r/s union
    .load_data (load_data),
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .dec_ex
  );

  // write port fed straight from the result stage outputs
  fpu_regfile regfile_i (
    .CLK, .nRST,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .we    (wb_en),
    .waddr (wb_rd),
    .wdata (wb_data)
  );

  fpu_execute execute_i (.CLK, .nRST, .dec_ex, .ex_res);

  fpu_result result_i (
    .CLK, .nRST, .ex_res,
    .done, .wb_en, .store_valid,
    .wb_rd, .wb_data, .store_data,
    .fflags
  );

endmodule

`default_nettype wire

// ==== fpu_mul.sv ====
// truncating single-precision multiplier with ftz, special cases and flags
`timescale 1ns/1ns
`default_nettype none

module fpu_mul (
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] prod,
  output logic [4:0]  flags
);

  logic               sa, sb, sp;
  logic [7:0]         ea, eb;
  logic [23:0]        ma, mb;
  logic               za, zb;
  logic               a_inf, b_inf, a_nan, b_nan, a_snan, b_snan;
  logic [47:0]        p;
  logic signed [9:0]  exp_p;
  logic [22:0]        frac;
  logic               lost;

  assign sa = a[31];
  assign sb = b[31];
  assign sp = sa ^ sb;
  assign ea = a[30:23];
  assign eb = b[30:23];
  assign za = (ea == 8'h00); // zero or flushed subnormal
  assign zb = (eb == 8'h00);
  assign ma = za ? 24'd0 : {1'b1, a[22:0]};
  assign mb = zb ? 24'd0 : {1'b1, b[22:0]};

  assign a_inf  = (ea == 8'hff) && (a[22:0] == 23'd0);
  assign b_inf  = (eb == 8'hff) && (b[22:0] == 23'd0);
  assign a_nan  = (ea == 8'hff) && (a[22:0] != 23'd0);
  assign b_nan  = (eb == 8'hff) && (b[22:0] != 23'd0);
  assign a_snan = a_nan && !a[22];
  assign b_snan = b_nan && !b[22];

  assign p = ma * mb; // product in [1,4), leading one at 47 or 46

  // rebias, one more if the product reached 2.0
  assign exp_p = $signed({2'b00, ea}) + $signed({2'b00, eb}) - 10'sd127
               + (p[47] ? 10'sd1 : 10'sd0);
  assign frac  = p[47] ? p[46:24] : p[45:23];
  assign lost  = p[47] ? |p[23:0] : |p[22:0]; // bits cut by truncation

  always_comb begin
    flags = 5'd0;
    if (a_nan || b_nan) begin
      prod                    = fpu_pkg::CANON_NAN;
      flags[fpu_pkg::FLAG_NV] = a_snan || b_snan;
    end else if ((a_inf && zb) || (b_inf && za)) begin
      prod                    = fpu_pkg::CANON_NAN; // 0 * inf
      flags[fpu_pkg::FLAG_NV] = 1'b1;
    end else if (a_inf || b_inf) begin
      prod = {sp, 8'hff, 23'd0};
    end else if (za || zb) begin
      prod = {sp, 31'd0}; // signed zero
    end else if (exp_p >= 10'sd255) begin
      prod                    = {sp, 8'hfe, {23{1'b1}}}; // rtz clamp
      flags[fpu_pkg::FLAG_OF] = 1'b1;
      flags[fpu_pkg::FLAG_NX] = 1'b1;
    end else if (exp_p <= 10'sd0) begin
      prod                    = {sp, 31'd0}; // subnormal range flushed
      flags[fpu_pkg::FLAG_UF] = 1'b1;
      flags[fpu_pkg::FLAG_NX] = 1'b1;
    end else begin
      prod                    = {sp, exp_p[7:0], frac};
      flags[fpu_pkg::FLAG_NX] = lost;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
// fpu extension package with opcodes, funct7 codes, flag positions, instruction union, stage structs
`default_nettype none

package fpu_pkg;

  localparam int NREGS = 32; // float register count

  // major opcodes
  localparam logic [6:0] OP_FLW = 7'b0000111;
  localparam logic [6:0] OP_FSW = 7'b0100111;
  localparam logic [6:0] OP_FP  = 7'b1010011;

  // funct7 for the supported OP-FP ops
  localparam logic [6:0] F7_FADD = 7'b0000000;
  localparam logic [6:0] F7_FSUB = 7'b0000100;
  localparam logic [6:0] F7_FMUL = 7'b0001000;

  // bit positions in the 5-bit fflags word, bit 3 (dz) unused
  localparam int FLAG_NV = 4;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam logic [31:0] CANON_NAN = 32'h7fc00000; // quiet, positive

  typedef enum logic [2:0] {
    FPU_NONE,
    FPU_LOAD,
    FPU_STORE,
    FPU_ADD,
    FPU_SUB,
    FPU_MUL
  } fpu_op_e;

  // r-type view, flw shares rd/rs1 positions
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;     // ignored, always rtz
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // s-type view for fsw
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;    // data register
    logic [4:0] rs1;    // integer base, host side
    logic [2:0] funct3;
    logic [4:0] imm_lo; // sits where rd would be
    logic [6:0] opcode;
  } s_fields_t;

  typedef union packed {
    r_fields_t r;
    s_fields_t s;
  } fpu_instr_u;

  typedef struct packed {
    logic        valid;
    fpu_op_e     op;
    logic [4:0]  rd;
    logic [31:0] a;         // rs1 value
    logic [31:0] b;         // rs2 value
    logic [31:0] load_data; // word from host for flw
  } dec_ex_t;

  typedef struct packed {
    logic        valid;
    fpu_op_e     op;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [4:0]  flags;
  } ex_res_t;

endpackage

`default_nettype wire

// ==== fpu_regfile.sv ====
// float register file, two combinational read ports and one write port
`timescale 1ns/1ns
`default_nettype none

module fpu_regfile (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [fpu_pkg::NREGS];

  // f0 is writable, all regs come up as +0
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < fpu_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, same-cycle write reads old value
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== fpu_result.sv ====
// result stage, write-back, store output, done pulse and sticky flags
`timescale 1ns/1ns
`default_nettype none

module fpu_result (
  input  logic              CLK,
  input  logic              nRST,
  input  fpu_pkg::ex_res_t  ex_res,
  output logic              done,
  output logic              wb_en,
  output logic              store_valid,
  output logic [4:0]        wb_rd,
  output logic [31:0]       wb_data,
  output logic [31:0]       store_data,
  output logic [4:0]        fflags
);

  logic is_store;

  assign is_store = (ex_res.op == fpu_pkg::FPU_STORE);

  // one-cycle pulses and sticky flag accumulation
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done        <= 1'b0;
      wb_en       <= 1'b0;
      store_valid <= 1'b0;
      fflags      <= 5'd0;
    end else begin
      done        <= ex_res.valid;
      wb_en       <= ex_res.valid && !is_store;
      store_valid <= ex_res.valid && is_store;
      if (ex_res.valid) fflags <= fflags | ex_res.flags; // or in, never cleared
    end
  end

  // payload, only meaningful with its strobe
  always_ff @(posedge CLK) begin
    wb_rd      <= ex_res.rd;
    wb_data    <= ex_res.value;
    store_data <= ex_res.value;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
fpu_pkg.sv
fpu_regfile.sv
fpu_add_sub.sv
fpu_mul.sv
fpu_decode.sv
fpu_execute.sv
fpu_result.sv
fpu_ext_top.sv
tb_fpu_ext.sv

// ==== tb_fpu_ext.sv ====
// fpu extension testbench with instruction driver, reference model, completion checker and assertions
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_ext;

  // one expected completion
  typedef struct packed {
    logic [31:0] cyc;   // cycle count when done is due
    logic        st;    // store, else write-back
    logic [4:0]  rd;
    logic [31:0] val;
    logic [4:0]  flags;
  } exp_t;

  logic        CLK = 1'b0;
  logic        nRST, start;
  logic [31:0] instr, load_data;
  logic        done, wb_en, store_valid;
  logic [4:0]  wb_rd, fflags;
  logic [31:0] wb_data, store_data;

  exp_t        expq[$];          // kept in issue order since the pipeline never reorders
  logic [31:0] model_regs [32];  // float register mirror
  logic [4:0]  flag_acc = 5'd0;  // or of flags of completed instrs
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  integer      seed = 32'he495;

  fpu_ext_top fpu_ext_top_i (
    .CLK, .nRST, .start, .instr, .load_data,
    .done, .wb_en, .wb_rd, .wb_data, .store_valid, .store_data, .fflags
  );

  always #5 CLK = ~CLK;
  always @(posedge CLK) cyc <= cyc + 1; // edge count

  // exact encoding of an integer below 2^24
  function automatic logic [31:0] int_to_f32(input int v);
    logic [31:0] m;
    int          p;
    m = (v < 0) ? -v : v;
    p = 0;
    for (int i = 0; i < 32; i++) begin
      if (m[i]) p = i; // msb position
    end
    m = m << (23 - p);
    return (v == 0) ? 32'd0 : {v < 0, 8'(127 + p), m[22:0]};
  endfunction

  function automatic logic [31:0] pow2(input int e);
    return {1'b0, 8'(127 + e), 23'd0};
  endfunction

  // integer product where a zero keeps the xor of the signs
  function automatic logic [31:0] mul_ref(input int a, input int b);
    return (a * b == 0) ? {(a < 0) ^ (b < 0), 31'd0} : int_to_f32(a * b);
  endfunction

  function automatic logic [4:0] fmask(input logic nv, input logic of, input logic uf,
                                       input logic nx);
    logic [4:0] m;
    m = 5'd0;
    m[fpu_pkg::FLAG_NV] = nv;
    m[fpu_pkg::FLAG_OF] = of;
    m[fpu_pkg::FLAG_UF] = uf;
    m[fpu_pkg::FLAG_NX] = nx;
    return m;
  endfunction

  function automatic logic [31:0] flw_word(input logic [4:0] rd);
    return {12'h010, 5'd2, 3'b010, rd, fpu_pkg::OP_FLW}; // base and offset unused here
  endfunction

  function automatic logic [31:0] fsw_word(input logic [4:0] rs2);
    return {7'h01, rs2, 5'd2, 3'b010, 5'h1c, fpu_pkg::OP_FSW}; // imm_lo in the rd slot
  endfunction

  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b111, rd, fpu_pkg::OP_FP}; // dynamic rm has no effect
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("error %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // called 1 ns after an edge and returns 1 ns after the next
  task automatic issue(input logic [31:0] word, input logic [31:0] ld, input logic has_done,
                       input exp_t e);
    exp_t q;
    q = e;
    q.cyc = cyc + 3; // done in the third cycle after this one
    start = 1'b1;
    instr = word;
    load_data = ld;
    if (has_done) expq.push_back(q);
    @(posedge CLK);
    #1;
    start = 1'b0;
    instr = $random(seed); // junk while idle
    load_data = $random(seed);
  endtask

  // wait out all outstanding completions, then one more edge for the rf write
  task automatic drain();
    int n;
    n = 0;
    while (expq.size() != 0 && n < 20) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (expq.size() != 0) begin
      timeouts++;
      $display("timeout waiting for %0d outstanding completions", expq.size());
      expq.delete();
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
    issue(flw_word(rd), val, 1'b1, {32'd0, 1'b0, rd, val, 5'd0});
    model_regs[rd] = val;
  endtask

  task automatic store_reg(input logic [4:0] rs2);
    issue(fsw_word(rs2), $random(seed), 1'b1, {32'd0, 1'b1, 5'd0, model_regs[rs2], 5'd0});
  endtask

  task automatic arith(input logic [6:0] f7, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [31:0] val, input logic [4:0] fl);
    issue(op_word(f7, rd, rs1, rs2), 32'd0, 1'b1, {32'd0, 1'b0, rd, val, fl});
    model_regs[rd] = val;
  endtask

  // completion checker sampling at the falling edge where outputs are stable
  always @(negedge CLK) begin
    exp_t e;
    if (nRST) begin
      if (done && expq.size() == 0) begin
        errors++;
        $display("done pulsed with nothing outstanding at cycle %0d", cyc);
      end else if (done) begin
        e = expq.pop_front();
        flag_acc = flag_acc | e.flags;
        check("done cycle", 32'(cyc), e.cyc);
        check("store_valid", 32'(store_valid), 32'(e.st));
        if (e.st) begin
          check("store_data", store_data, e.val);
        end else begin
          check("wb_rd", 32'(wb_rd), 32'(e.rd));
          check("wb_data", wb_data, e.val);
        end
      end else if (expq.size() != 0 && expq[0].cyc <= cyc) begin
        errors++;
        $display("done missing for an instruction due at cycle %0d", expq[0].cyc);
        e = expq.pop_front();
      end
      check("fflags", 32'(fflags), 32'(flag_acc)); // sticky or so far
    end
  end

  // strobes only with done, and one kind at a time
  a_one_strobe: assert property (@(negedge CLK) disable iff (!nRST)
                                 done |-> (wb_en ^ store_valid))
    else begin
      errors++;
      $display("done came without exactly one of wb_en and store_valid");
    end

  a_quiet: assert property (@(negedge CLK) disable iff (!nRST)
                            !done |-> !(wb_en || store_valid))
    else begin
      errors++;
      $display("write or store strobe without done");
    end

  a_no_dz: assert property (@(negedge CLK) disable iff (!nRST) !fflags[3])
    else begin
      errors++;
      $display("divide by zero flag raised");
    end

  initial begin
    int ia, ib;
    nRST = 1'b0;
    start = 1'b0;
    instr = 32'd0;
    load_data = 32'd0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0; // rf resets to +0
    end
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    idle(3);
    store_reg(5'd0); // reset contents
    store_reg(5'd31);
    drain();
    load_reg(5'd1, int_to_f32(3));
    drain();
    store_reg(5'd1);
    drain();
    load_reg(5'd2, int_to_f32(-5));
    load_reg(5'd3, int_to_f32(12));
    load_reg(5'd4, int_to_f32(12));
    drain();
    // back to back with three in flight
    arith(fpu_pkg::F7_FADD, 5'd10, 5'd1, 5'd2, int_to_f32(-2), 5'd0);
    arith(fpu_pkg::F7_FSUB, 5'd11, 5'd3, 5'd4, 32'd0, 5'd0); // exact cancel is +0
    arith(fpu_pkg::F7_FMUL, 5'd12, 5'd1, 5'd2, int_to_f32(-15), 5'd0);
    arith(fpu_pkg::F7_FSUB, 5'd13, 5'd2, 5'd3, int_to_f32(-17), 5'd0);
    drain();
    store_reg(5'd11);
    store_reg(5'd12);
    drain();
    for (int i = 0; i < 8; i++) begin
      ia = $random(seed) % 2048; // sums and products stay exact
      ib = $random(seed) % 2048;
      load_reg(5'd20, int_to_f32(ia));
      load_reg(5'd21, int_to_f32(ib));
      drain();
      arith(fpu_pkg::F7_FADD, 5'd22, 5'd20, 5'd21, int_to_f32(ia + ib), 5'd0);
      arith(fpu_pkg::F7_FSUB, 5'd23, 5'd20, 5'd21, int_to_f32(ia - ib), 5'd0);
      arith(fpu_pkg::F7_FMUL, 5'd24, 5'd20, 5'd21, mul_ref(ia, ib), 5'd0);
      drain();
    end
    // special operands
    load_reg(5'd1, 32'h7f800000);
    load_reg(5'd2, 32'h7f800000);
    load_reg(5'd3, 32'd0);
    load_reg(5'd4, pow2(100));
    load_reg(5'd5, pow2(-100));
    load_reg(5'd6, pow2(0));
    load_reg(5'd7, pow2(-30));
    drain();
    arith(fpu_pkg::F7_FSUB, 5'd8, 5'd1, 5'd2, fpu_pkg::CANON_NAN, fmask(1'b1, 1'b0, 1'b0, 1'b0));
    arith(fpu_pkg::F7_FMUL, 5'd9, 5'd3, 5'd1, fpu_pkg::CANON_NAN, fmask(1'b1, 1'b0, 1'b0, 1'b0));
    arith(fpu_pkg::F7_FMUL, 5'd10, 5'd5, 5'd5, 32'd0, fmask(1'b0, 1'b0, 1'b1, 1'b1));
    arith(fpu_pkg::F7_FMUL, 5'd11, 5'd4, 5'd4, 32'h7f7fffff, fmask(1'b0, 1'b1, 1'b0, 1'b1));
    arith(fpu_pkg::F7_FADD, 5'd12, 5'd6, 5'd7, pow2(0), fmask(1'b0, 1'b0, 1'b0, 1'b1));
    drain();
    // unsupported words expect no done
    issue({7'b0101100, 5'd1, 5'd2, 3'b000, 5'd13, fpu_pkg::OP_FP}, 32'd0, 1'b0, '0);
    issue({7'd0, 5'd1, 5'd2, 3'b000, 5'd13, 7'b0110011}, 32'd0, 1'b0, '0);
    idle(6);
    store_reg(5'd13); // f13 untouched
    drain();
    end_run();
  end

endmodule

`default_nettype wire
